/* src/dcache_pkg.sv */
package dcache_pkg;

    // Core and bus word width
    localparam int data_width = 64;

    // Line geometry, eight 64-bit words per line
    localparam int beats_per_line = 8;
    localparam int line_offset_width = 6;

    // Access size codes as the core sends them
    typedef logic [2:0] size_t;

    localparam size_t size_byte = 3'd1;
    localparam size_t size_half = 3'd2;
    localparam size_t size_word = 3'd4;
    localparam size_t size_double = 3'd7;

    // AXI burst fields for one whole line
    localparam logic [7:0] axi_len_line = 8'd7;    // Eight beats
    localparam logic [2:0] axi_size_word = 3'd3;   // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'd1;

endpackage

/* src/lane_align.sv */
`timescale 1ns/100ps

module lane_align (
    input  logic [63:0] read_word,
    input  logic [2:0] byte_offset,
    input  dcache_pkg::size_t data_size,
    input  logic load_sign,
    input  logic [63:0] data_input,
    output logic [63:0] data_out,
    output logic [63:0] store_word,
    output logic [7:0] store_mask
);

    logic [63:0] shifted;
    logic [7:0] lanes;

    // Addressed load bytes moved down to bit 0
    always_comb begin
        shifted = read_word >> {byte_offset, 3'b000};
        case (data_size)
            dcache_pkg::size_byte: data_out = {{56{load_sign & shifted[7]}}, shifted[7:0]};
            dcache_pkg::size_half: data_out = {{48{load_sign & shifted[15]}}, shifted[15:0]};
            dcache_pkg::size_word: data_out = {{32{load_sign & shifted[31]}}, shifted[31:0]};
            default: data_out = shifted;    // Double word
        endcase
    end

    // Store byte-lane mask follows the access size
    always_comb begin
        case (data_size)
            dcache_pkg::size_byte: lanes = 8'h01;
            dcache_pkg::size_half: lanes = 8'h03;
            dcache_pkg::size_word: lanes = 8'h0f;
            default: lanes = 8'hff;
        endcase
        store_mask = lanes << byte_offset;
        store_word = data_input << {byte_offset, 3'b000};
    end

endmodule

/* src/line_store.sv */
`timescale 1ns/100ps

module line_store #(
    parameter int sets = 4,
    parameter int ways = 2
) (
    input  logic clock,
    input  logic [$clog2(sets)-1:0] set_index,
    input  logic [$clog2(ways)-1:0] way,
    input  logic [2:0] word_index,
    input  logic [dcache_pkg::beats_per_line-1:0][63:0] fill_line,
    input  logic fill,
    input  logic [63:0] store_word,
    input  logic [7:0] store_mask,
    input  logic store_write,
    output logic [63:0] read_word,
    output logic [dcache_pkg::beats_per_line-1:0][63:0] victim_line
);

    // One packed line per set and way
    logic [dcache_pkg::beats_per_line-1:0][63:0] lines [sets][ways];

    assign read_word = lines[set_index][way][word_index];
    assign victim_line = lines[set_index][way];    // Whole line for write-back

    always_ff @(posedge clock) begin
        if (fill) begin
            lines[set_index][way] <= fill_line;
        end else if (store_write) begin
            // Merge only the enabled byte lanes
            for (int b = 0; b < 8; b++) begin
                if (store_mask[b])
                    lines[set_index][way][word_index][b*8 +: 8] <= store_word[b*8 +: 8];
            end
        end
    end

endmodule

/* src/tag_store.sv */
`timescale 1ns/100ps

module tag_store #(
    parameter int sets = 4,
    parameter int ways = 2,
    parameter int addr_width = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic [addr_width-1:0] address,
    input  logic install,
    input  logic set_dirty,
    output logic hit,
    output logic [$clog2(ways)-1:0] hit_way,
    output logic [$clog2(ways)-1:0] victim_way,
    output logic [addr_width-$clog2(sets)-dcache_pkg::line_offset_width-1:0] victim_tag,
    output logic victim_dirty
);

    localparam int index_width = $clog2(sets);
    localparam int way_width = $clog2(ways);
    localparam int tag_width = addr_width - index_width - dcache_pkg::line_offset_width;

    logic [tag_width-1:0] tags [sets][ways];
    logic [ways-1:0] valid [sets];
    logic [ways-1:0] dirty [sets];
    logic [way_width-1:0] rr_count;    // Round-robin pointer for full sets
    logic [index_width-1:0] index;
    logic [tag_width-1:0] tag;

    assign index = address[dcache_pkg::line_offset_width +: index_width];
    assign tag = address[addr_width-1 -: tag_width];

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                hit = 1'b1;
                hit_way = w[way_width-1:0];
            end
        end
    end

    // Downward loop so the lowest invalid way wins
    always_comb begin
        victim_way = rr_count;
        for (int w = ways - 1; w >= 0; w--) begin
            if (!valid[index][w])
                victim_way = w[way_width-1:0];
        end
    end

    assign victim_tag = tags[index][victim_way];
    assign victim_dirty = valid[index][victim_way] & dirty[index][victim_way];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            rr_count <= '0;
        end else if (install) begin
            valid[index][victim_way] <= 1'b1;
            dirty[index][victim_way] <= 1'b0;    // Fresh line from memory
            if (&valid[index])
                rr_count <= (rr_count == way_width'(ways - 1)) ? '0 : rr_count + 1'b1;
        end else if (set_dirty) begin
            dirty[index][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (install)
            tags[index][victim_way] <= tag;
    end

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int sets = 4,
    parameter int ways = 2,
    parameter int addr_width = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic read_enable,
    input  logic write_enable,
    input  logic hit,
    input  logic fill_done,
    input  logic evict_done,
    input  logic victim_dirty,
    output logic send_enable,
    output logic start_fill,
    output logic start_evict,
    output logic install,
    output logic store_write,
    output logic lookup_select_victim
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_evict = 3'd1;      // Dirty victim going out
    localparam logic [2:0] st_fill = 3'd2;       // Line coming in
    localparam logic [2:0] st_install = 3'd3;
    localparam logic [2:0] st_access = 3'd4;     // Replay on the installed line
    localparam logic [2:0] st_done = 3'd5;

    logic [2:0] state;
    logic request;

    assign request = read_enable | write_enable;

    // Line store points at the victim while a miss is in flight
    assign lookup_select_victim = (state == st_evict) || (state == st_fill) ||
                                  (state == st_install);
    assign install = (state == st_install);

    // Store lands on the same edge that raises send_enable
    assign store_write = write_enable && hit && ((state == st_idle) || (state == st_access));

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            send_enable <= 1'b0;
            start_fill <= 1'b0;
            start_evict <= 1'b0;
        end else begin
            send_enable <= 1'b0;    // All three are single-cycle pulses
            start_fill <= 1'b0;
            start_evict <= 1'b0;
            case (state)
                st_idle: begin
                    if (request) begin
                        if (hit) begin
                            state <= st_done;
                            send_enable <= 1'b1;
                        end else if (victim_dirty) begin
                            state <= st_evict;
                            start_evict <= 1'b1;
                        end else begin
                            state <= st_fill;
                            start_fill <= 1'b1;
                        end
                    end
                end
                st_evict: begin
                    if (evict_done) begin
                        state <= st_fill;
                        start_fill <= 1'b1;
                    end
                end
                st_fill: begin
                    if (fill_done)
                        state <= st_install;
                end
                st_install: state <= st_access;
                st_access: begin
                    state <= st_done;
                    send_enable <= 1'b1;
                end
                // Core drops its enable on this edge
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* src/line_mover.sv */
`timescale 1ns/100ps

module line_mover #(
    parameter int addr_width = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic start_fill,
    input  logic [addr_width-1:0] fill_address,
    input  logic start_evict,
    input  logic [addr_width-1:0] evict_address,
    input  logic [dcache_pkg::beats_per_line-1:0][63:0] evict_line,
    output logic [dcache_pkg::beats_per_line-1:0][63:0] fill_line,
    output logic fill_done,
    output logic evict_done,
    output logic arvalid,
    output logic [addr_width-1:0] araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    input  logic arready,
    input  logic rvalid,
    input  logic [63:0] rdata,
    input  logic rlast,
    output logic rready,
    output logic awvalid,
    output logic [addr_width-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    input  logic awready,
    output logic wvalid,
    output logic [63:0] wdata,
    output logic [7:0] wstrb,
    output logic wlast,
    input  logic wready,
    input  logic bvalid,
    output logic bready
);

    localparam int beat_width = $clog2(dcache_pkg::beats_per_line);

    logic [beat_width-1:0] beat;    // Fill and evict never overlap so they share it
    logic [dcache_pkg::beats_per_line-1:0][63:0] evict_buffer;

    assign arlen = dcache_pkg::axi_len_line;
    assign arsize = dcache_pkg::axi_size_word;
    assign arburst = dcache_pkg::axi_burst_incr;
    assign awlen = dcache_pkg::axi_len_line;
    assign awsize = dcache_pkg::axi_size_word;
    assign awburst = dcache_pkg::axi_burst_incr;
    assign wstrb = 8'hff;
    assign wdata = evict_buffer[beat];
    assign wlast = wvalid && (beat == beat_width'(dcache_pkg::beats_per_line - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            fill_done <= 1'b0;
            evict_done <= 1'b0;
            beat <= '0;
        end else begin
            fill_done <= 1'b0;
            evict_done <= 1'b0;
            if (start_fill) begin
                arvalid <= 1'b1;
                beat <= '0;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready <= 1'b1;
            end else if (rvalid && rready) begin
                beat <= beat + 1'b1;
                if (rlast) begin
                    rready <= 1'b0;
                    fill_done <= 1'b1;
                end
            end
            // Address and first data beat go out together
            if (start_evict) begin
                awvalid <= 1'b1;
                wvalid <= 1'b1;
                beat <= '0;
            end else begin
                if (awvalid && awready)
                    awvalid <= 1'b0;
                if (wvalid && wready) begin
                    beat <= beat + 1'b1;
                    if (wlast) begin
                        wvalid <= 1'b0;
                        bready <= 1'b1;
                    end
                end
                if (bvalid && bready) begin
                    bready <= 1'b0;
                    evict_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_fill)
            araddr <= fill_address;
        if (start_evict) begin
            awaddr <= evict_address;
            evict_buffer <= evict_line;    // Victim copied before the refill overwrites it
        end
        if (rvalid && rready)
            fill_line[beat] <= rdata;
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top #(
    parameter int sets = 4,
    parameter int ways = 2,
    parameter int addr_width = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic read_enable,
    input  logic write_enable,
    input  logic [addr_width-1:0] address,
    input  dcache_pkg::size_t data_size,
    input  logic [63:0] data_input,
    input  logic load_sign,
    output logic [63:0] data_out,
    output logic send_enable,
    output logic arvalid,
    output logic [addr_width-1:0] araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    input  logic arready,
    input  logic rvalid,
    input  logic [63:0] rdata,
    input  logic rlast,
    output logic rready,
    output logic awvalid,
    output logic [addr_width-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    input  logic awready,
    output logic wvalid,
    output logic [63:0] wdata,
    output logic [7:0] wstrb,
    output logic wlast,
    input  logic wready,
    input  logic bvalid,
    input  logic [1:0] bresp,
    output logic bready
);

    localparam int offset_width = dcache_pkg::line_offset_width;
    localparam int index_width = $clog2(sets);
    localparam int tag_width = addr_width - index_width - offset_width;

    logic hit, victim_dirty, fill_done, evict_done;
    logic start_fill, start_evict, install, store_write, lookup_select_victim;
    logic [$clog2(ways)-1:0] hit_way, victim_way, line_way;
    logic [tag_width-1:0] victim_tag;
    logic [index_width-1:0] set_index;
    logic [addr_width-1:0] fill_address, evict_address;
    logic [dcache_pkg::beats_per_line-1:0][63:0] fill_line, victim_line;
    logic [63:0] read_word, store_word;
    logic [7:0] store_mask;

    assign set_index = address[offset_width +: index_width];
    assign line_way = lookup_select_victim ? victim_way : hit_way;
    // Line-aligned burst addresses
    assign fill_address = {address[addr_width-1:offset_width], {offset_width{1'b0}}};
    assign evict_address = {victim_tag, set_index, {offset_width{1'b0}}};

    dcache_ctrl #(.sets(sets), .ways(ways), .addr_width(addr_width)) ctrl (
        .clock(clock), .reset(reset),
        .read_enable(read_enable), .write_enable(write_enable),
        .hit(hit), .fill_done(fill_done), .evict_done(evict_done),
        .victim_dirty(victim_dirty), .send_enable(send_enable),
        .start_fill(start_fill), .start_evict(start_evict), .install(install),
        .store_write(store_write), .lookup_select_victim(lookup_select_victim)
    );

    tag_store #(.sets(sets), .ways(ways), .addr_width(addr_width)) tags (
        .clock(clock), .reset(reset), .address(address),
        .install(install), .set_dirty(store_write),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_tag(victim_tag), .victim_dirty(victim_dirty)
    );

    line_store #(.sets(sets), .ways(ways)) lines (
        .clock(clock), .set_index(set_index), .way(line_way),
        .word_index(address[offset_width-1:3]), .fill_line(fill_line), .fill(install),
        .store_word(store_word), .store_mask(store_mask), .store_write(store_write),
        .read_word(read_word), .victim_line(victim_line)
    );

    lane_align align (
        .read_word(read_word), .byte_offset(address[2:0]), .data_size(data_size),
        .load_sign(load_sign), .data_input(data_input), .data_out(data_out),
        .store_word(store_word), .store_mask(store_mask)
    );

    line_mover #(.addr_width(addr_width)) mover (
        .clock(clock), .reset(reset),
        .start_fill(start_fill), .fill_address(fill_address),
        .start_evict(start_evict), .evict_address(evict_address),
        .evict_line(victim_line), .fill_line(fill_line),
        .fill_done(fill_done), .evict_done(evict_done),
        .arvalid(arvalid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arburst(arburst), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rlast(rlast), .rready(rready),
        .awvalid(awvalid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
        .awburst(awburst), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

endmodule

/* tb/axi_mem_model.sv */
`timescale 1ns/100ps

module axi_mem_model #(
    parameter int delay_seed = 1,
    parameter int words = 512
) (
    input  logic clock, reset,
    input  logic arvalid, rready, awvalid, wvalid, wlast, bready,
    input  logic [31:0] araddr, awaddr,
    input  logic [7:0] arlen, awlen, wstrb,
    input  logic [2:0] arsize, awsize,
    input  logic [1:0] arburst, awburst,
    input  logic [63:0] wdata,
    output logic arready, rvalid, rlast, awready, wready, bvalid,
    output logic [63:0] rdata,
    output logic [1:0] bresp,
    output int protocol_errors
);

    localparam int index_width = $clog2(words);

    logic [63:0] image [words];
    logic [63:0] write_buffer [8];
    logic [31:0] read_base, write_base;
    logic read_busy, read_hold, aw_taken, w_taken, b_accept;
    int read_beat, write_beat, seed;

    // Same pattern as the testbench reference image
    function automatic logic [7:0] fill_byte(input int addr);
        return 8'((addr * 37) ^ (addr >> 7) ^ 8'h5c);
    endfunction

    function automatic logic random_ready();
        return ($random(seed) & 3) != 0;    // Ready about three cycles in four
    endfunction

    // Eight beats of 8 bytes, incrementing, line aligned
    function automatic logic burst_ok(input logic [7:0] len, input logic [2:0] size,
                                      input logic [1:0] burst, input logic [31:0] addr);
        return len == 8'd7 && size == 3'd3 && burst == 2'd1 && addr[5:0] == 6'd0;
    endfunction

    task automatic report(input string what);
        protocol_errors++;
        $display("Memory model at %0t: %s", $time, what);
    endtask

    initial begin
        seed = delay_seed;
        protocol_errors = 0;
        {arready, rvalid, rlast, awready, wready, bvalid} = '0;
        rdata = '0;
        bresp = 2'b00;    // Always OKAY
        {read_busy, aw_taken, w_taken} = '0;
        read_base = '0;
        write_base = '0;
        read_beat = 0;
        write_beat = 0;
        for (int a = 0; a < words * 8; a++)
            image[index_width'(a / 8)][(a % 8) * 8 +: 8] = fill_byte(a);
        forever begin
            @(posedge clock);
            read_hold = rvalid && !rready;    // Unaccepted beat must stay up
            b_accept = bvalid && bready;
            if (reset) begin
                {read_busy, aw_taken, w_taken} = '0;
                read_beat = 0;
                write_beat = 0;
            end else begin
                if (arvalid && arready) begin
                    if (!burst_ok(arlen, arsize, arburst, araddr))
                        report($sformatf("bad read burst len %0d size %0d type %0d addr %h",
                                         arlen, arsize, arburst, araddr));
                    read_busy = 1'b1;
                    read_base = araddr;
                    read_beat = 0;
                end else if (rvalid && rready) begin
                    read_beat++;
                    read_busy = read_beat < 8;
                end
                if (awvalid && awready) begin
                    if (!burst_ok(awlen, awsize, awburst, awaddr))
                        report($sformatf("bad write burst len %0d size %0d type %0d addr %h",
                                         awlen, awsize, awburst, awaddr));
                    aw_taken = 1'b1;
                    write_base = awaddr;
                end
                if (wvalid && wready) begin
                    if (wstrb != 8'hff)
                        report($sformatf("write beat %0d has strobe %h", write_beat, wstrb));
                    if (wlast != (write_beat == 7))
                        report($sformatf("wlast is %0b on write beat %0d", wlast, write_beat));
                    write_buffer[3'(write_beat)] = wdata;
                    write_beat++;
                    w_taken = wlast;
                end
                if (b_accept) begin
                    {aw_taken, w_taken} = '0;
                    write_beat = 0;
                end
            end
            #1;
            if (reset) begin
                {arready, rvalid, rlast, awready, wready, bvalid} = '0;
            end else begin
                arready = !read_busy && random_ready();
                rvalid = read_busy && (read_hold || random_ready());
                rlast = read_beat == 7;
                rdata = image[index_width'((read_base >> 3) + read_beat)];
                awready = !aw_taken && random_ready();
                wready = !w_taken && random_ready();
                if (b_accept) begin
                    bvalid = 1'b0;
                end else if (!bvalid && aw_taken && w_taken && random_ready()) begin
                    for (int i = 0; i < 8; i++)
                        image[index_width'((write_base >> 3) + i)] = write_buffer[i];
                    bvalid = 1'b1;    // Image updated before the response
                end
            end
        end
    end

endmodule

/* tb/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb;

    localparam int load_count = 64;
    localparam int store_count = 48;
    localparam int repeat_count = 24;
    localparam int mix_count = 300;
    localparam int flush_count = 16;
    localparam int total_accesses = load_count + 3 * store_count + repeat_count + 1 +
                                    mix_count + flush_count;

    logic clock, reset, read_enable, write_enable, load_sign, send_enable;
    logic arvalid, arready, rvalid, rlast, rready, awvalid, awready;
    logic wvalid, wlast, wready, bvalid, bready;
    logic [31:0] address, araddr, awaddr;
    logic [63:0] data_input, data_out, rdata, wdata;
    logic [7:0] arlen, awlen, wstrb;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst, bresp;
    dcache_pkg::size_t data_size;
    int protocol_errors;

    logic [7:0] ref_mem [4096];    // Reference byte image of memory
    int seed, checks, errors, latency;

    dcache_top #(.sets(4), .ways(2), .addr_width(32)) uut (.*);
    axi_mem_model #(.delay_seed(32'hd57a_5658), .words(512)) memory (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Each access gets 200 cycles of 8 ns
    initial begin
        #(total_accesses * 200 * 8);
        $display("Watchdog expired, a cache request did not complete in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [7:0] fill_byte(input int addr);
        return 8'((addr * 37) ^ (addr >> 7) ^ 8'h5c);
    endfunction

    function automatic int byte_count(input dcache_pkg::size_t size);
        case (size)
            dcache_pkg::size_byte: return 1;
            dcache_pkg::size_half: return 2;
            dcache_pkg::size_word: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic dcache_pkg::size_t random_size();
        case ($random(seed) & 3)
            0: return dcache_pkg::size_byte;
            1: return dcache_pkg::size_half;
            2: return dcache_pkg::size_word;
            default: return dcache_pkg::size_double;
        endcase
    endfunction

    // Little-endian gather, then extension above the top byte
    function automatic logic [63:0] model_load(input logic [31:0] addr,
                                               input dcache_pkg::size_t size, input logic sign);
        logic [63:0] value;
        int n;
        value = '0;
        n = byte_count(size);
        for (int i = 0; i < n; i++)
            value[i*8 +: 8] = ref_mem[12'(addr + 32'(i))];
        if (sign && n < 8 && value[n*8-1])
            value = value | ({64{1'b1}} << (n * 8));
        return value;
    endfunction

    function automatic logic [63:0] model_word(input int w);
        logic [63:0] word;
        for (int b = 0; b < 8; b++)
            word[b*8 +: 8] = ref_mem[12'(w * 8 + b)];
        return word;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic run_access(input logic is_write, input logic [31:0] addr,
                              input dcache_pkg::size_t size, input logic sign,
                              input logic [63:0] value);
        int cycles;
        address = addr;
        data_size = size;
        load_sign = sign;
        data_input = value;
        read_enable = !is_write;
        write_enable = is_write;
        cycles = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
        end while (!send_enable);
        latency = cycles;
        if (is_write) begin
            for (int i = 0; i < byte_count(size); i++)
                ref_mem[12'(addr + 32'(i))] = value[i*8 +: 8];
        end else begin
            check_value($sformatf("data_out @%h", addr), data_out, model_load(addr, size, sign));
        end
        @(posedge clock);
        #1;
        read_enable = 1'b0;    // Dropped on the edge that saw send_enable
        write_enable = 1'b0;
    endtask

    task automatic random_access(input logic [31:0] base, input logic [31:0] span,
                                 input logic allow_store);
        dcache_pkg::size_t size;
        logic [31:0] addr;
        logic is_write;
        size = random_size();
        addr = base + (($random(seed) & span) & ~(byte_count(size) - 1));
        is_write = allow_store && 1'($random(seed));
        run_access(is_write, addr, size, 1'($random(seed)), {$random(seed), $random(seed)});
    endtask

    task automatic test_done(input string name, input int mark);
        $display("%-14s done, %0d mismatches", name, errors + protocol_errors - mark);
    endtask

    initial begin
        dcache_pkg::size_t size;
        logic [31:0] addr;
        int mark;
        seed = 32'hd57a_5658;
        checks = 0;
        errors = 0;
        reset = 1'b1;
        {read_enable, write_enable, load_sign} = '0;
        address = '0;
        data_size = dcache_pkg::size_double;
        data_input = '0;
        for (int a = 0; a < 4096; a++)
            ref_mem[a] = fill_byte(a);
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;

        mark = errors + protocol_errors;
        for (int i = 0; i < load_count; i++)
            random_access(32'h0, 32'h7ff, 1'b0);
        test_done("load_sizes", mark);

        // Store, then the whole double word, then the same access back
        mark = errors + protocol_errors;
        for (int i = 0; i < store_count; i++) begin
            size = random_size();
            addr = ($random(seed) & 32'h7ff) & ~(byte_count(size) - 1);
            run_access(1'b1, addr, size, 1'b0, {$random(seed), $random(seed)});
            run_access(1'b0, addr & ~32'h7, dcache_pkg::size_double, 1'b0, '0);
            run_access(1'b0, addr, size, 1'($random(seed)), '0);
        end
        test_done("store_merge", mark);

        mark = errors + protocol_errors;
        run_access(1'b0, 32'h140, dcache_pkg::size_double, 1'b0, '0);
        for (int i = 0; i < repeat_count; i++) begin
            random_access(32'h140, 32'h3f, 1'b1);
            check_value("send_enable latency", 64'(latency), 64'd1);
        end
        test_done("hit_latency", mark);

        mark = errors + protocol_errors;
        for (int i = 0; i < mix_count; i++)
            random_access(32'h0, 32'h7ff, 1'b1);
        test_done("random_mix", mark);

        // Four clean aliasing lines per set push every dirty line out
        mark = errors + protocol_errors;
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 4; k++)
                run_access(1'b0, 32'h800 + 32'(k * 256 + s * 64), dcache_pkg::size_double,
                           1'b0, '0);
        end
        for (int w = 0; w < 512; w++)
            check_value($sformatf("memory image[%0d]", w), memory.image[9'(w)], model_word(w));
        test_done("writeback", mark);

        $display("%0d checks, %0d mismatches, %0d memory model errors",
                 checks, errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* dcache.f */
src/dcache_pkg.sv
src/lane_align.sv
src/line_store.sv
src/tag_store.sv
src/dcache_ctrl.sv
src/line_mover.sv
src/dcache_top.sv
tb/axi_mem_model.sv
tb/dcache_tb.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = dcache_tb
FILE_LIST = dcache.f
BUILD_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
